//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // --------------------------------------------------
    // bus and SRAM widths
    // --------------------------------------------------
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 32;
    localparam int BE_W    = DATA_W / 8;
    localparam int SRAM_AW = 20;

    // --------------------------------------------------
    // dbus region map
    // --------------------------------------------------

    // 8 MB of external RAM, split into two 4 MB banks by bit 22
    localparam logic [ADDR_W-1:0] RAM_BASE = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] RAM_MASK = 32'hff80_0000;

    localparam logic [ADDR_W-1:0] GPIO_BASE   = 32'hbfd0_0000;
    localparam logic [ADDR_W-1:0] TICK_BASE   = 32'hbfd0_0100;
    localparam logic [ADDR_W-1:0] PERIPH_MASK = 32'hffff_ff00;

    // --------------------------------------------------
    // bus and pin bundles
    // --------------------------------------------------

    // a master holds rd or wr high until it sees stall low
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
        logic              rd;
        logic              wr;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              stall;
    } bus_rsp_t;

    // all controls are active low, shared by both banks except the chip enables
    typedef struct packed {
        logic [SRAM_AW-1:0] addr;
        logic [BE_W-1:0]    be_n;
        logic               base_ce_n;
        logic               ext_ce_n;
        logic               oe_n;
        logic               we_n;
        logic [DATA_W-1:0]  wdata;
    } sram_pins_t;

    typedef struct packed {
        logic [8:0]         upper;
        logic               bank;
        logic [SRAM_AW-1:0] word;
        logic [1:0]         offset;
    } ram_addr_fields_t;

    // one address word, read either raw or split into its SRAM fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        ram_addr_fields_t  f;
    } ram_addr_u;

endpackage

`default_nettype wire

//--- logic/dbus_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module dbus_decoder import soc_pkg::*; (
    input  bus_req_t          dbus_req_i,
    output bus_rsp_t          dbus_rsp_o,

    output bus_req_t          ram_req_o,
    input  bus_rsp_t          ram_rsp_i,

    output bus_req_t          gpio_req_o,
    input  logic [DATA_W-1:0] gpio_rdata_i,

    output bus_req_t          tick_req_o,
    input  logic [DATA_W-1:0] tick_rdata_i
);

    ram_addr_u addr;
    logic      hit_ram;
    logic      hit_gpio;
    logic      hit_tick;

    assign addr = dbus_req_i.addr;

    // --------------------------------------------------
    // region match
    // --------------------------------------------------
    assign hit_ram  = (addr.raw & RAM_MASK) == RAM_BASE;
    assign hit_gpio = (addr.raw & PERIPH_MASK) == GPIO_BASE;
    assign hit_tick = (addr.raw & PERIPH_MASK) == TICK_BASE;

    // payload goes to every target, only the matching one sees a strobe
    always_comb begin
        ram_req_o     = dbus_req_i;
        ram_req_o.rd  = dbus_req_i.rd & hit_ram;
        ram_req_o.wr  = dbus_req_i.wr & hit_ram;

        gpio_req_o    = dbus_req_i;
        gpio_req_o.rd = dbus_req_i.rd & hit_gpio;
        gpio_req_o.wr = dbus_req_i.wr & hit_gpio;

        tick_req_o    = dbus_req_i;
        tick_req_o.rd = dbus_req_i.rd & hit_tick;
        tick_req_o.wr = dbus_req_i.wr & hit_tick;
    end

    // --------------------------------------------------
    // response return
    // --------------------------------------------------

    // the peripherals never stall, unmapped space reads as zero
    always_comb begin
        dbus_rsp_o.rdata = '0;
        dbus_rsp_o.stall = 1'b0;
        if (hit_ram) begin
            dbus_rsp_o = ram_rsp_i;
        end else if (hit_gpio) begin
            dbus_rsp_o.rdata = gpio_rdata_i;
        end else if (hit_tick) begin
            dbus_rsp_o.rdata = tick_rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/sram_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module sram_ctrl import soc_pkg::*; #(
    parameter int ACCESS_CYCLES = 2
) (
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  bus_req_t          port_a_req_i,
    output bus_rsp_t          port_a_rsp_o,
    input  bus_req_t          port_b_req_i,
    output bus_rsp_t          port_b_rsp_o,

    output sram_pins_t        sram_o,
    input  logic [DATA_W-1:0] sram_rdata_i
);

    localparam int CNT_W = $clog2(ACCESS_CYCLES + 1);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_STROBE = 2'd1;
    localparam logic [1:0] ST_DONE   = 2'd2;

    logic [1:0]        state_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              grant_q;
    bus_req_t          req_q;
    logic [DATA_W-1:0] rdata_q;

    logic      a_req;
    logic      b_req;
    logic      pick_b;
    logic      strobe;
    logic      last_cycle;
    ram_addr_u cur_addr;

    assign a_req = port_a_req_i.rd | port_a_req_i.wr;
    assign b_req = port_b_req_i.rd | port_b_req_i.wr;

    // grant_q also remembers who went last, so on a tie the other port wins
    assign pick_b = b_req & (~a_req | ~grant_q);

    assign strobe     = state_q == ST_STROBE;
    assign last_cycle = cnt_q == CNT_W'(ACCESS_CYCLES - 1);

    // --------------------------------------------------
    // access sequencer
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            grant_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (a_req | b_req) begin
                        state_q <= ST_STROBE;
                        cnt_q   <= '0;
                        grant_q <= pick_b;
                    end
                end
                ST_STROBE: begin
                    if (last_cycle) begin
                        state_q <= ST_DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && (a_req | b_req)) begin
            req_q <= pick_b ? port_b_req_i : port_a_req_i;
        end
        // the SRAM output has settled by the last strobe cycle
        if (strobe && last_cycle && !req_q.wr) begin
            rdata_q <= sram_rdata_i;
        end
    end

    // --------------------------------------------------
    // pins
    // --------------------------------------------------
    assign cur_addr = req_q.addr;

    always_comb begin
        sram_o.addr      = cur_addr.f.word;
        sram_o.be_n      = strobe ? ~req_q.be : '1;
        sram_o.base_ce_n = ~(strobe & ~cur_addr.f.bank);
        sram_o.ext_ce_n  = ~(strobe & cur_addr.f.bank);
        sram_o.oe_n      = ~(strobe & ~req_q.wr);
        sram_o.we_n      = ~(strobe & req_q.wr);
        sram_o.wdata     = req_q.wdata;
    end

    // a requesting port is held until its own done cycle
    assign port_a_rsp_o.rdata = rdata_q;
    assign port_a_rsp_o.stall = a_req & ~((state_q == ST_DONE) & ~grant_q);

    assign port_b_rsp_o.rdata = rdata_q;
    assign port_b_rsp_o.stall = b_req & ~((state_q == ST_DONE) & grant_q);

endmodule

`default_nettype wire

//--- logic/gpio_regs.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_regs import soc_pkg::*; (
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  bus_req_t          bus_req_i,
    output logic [DATA_W-1:0] rdata_o,

    input  logic [DATA_W-1:0] gpio_in_i,
    output logic [15:0]       leds_o
);

    logic [DATA_W-1:0] out_q;
    logic              sel_out;

    assign sel_out = bus_req_i.addr[7:0] == 8'h00;

    // byte lanes of the output register are written independently
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
        end else if (bus_req_i.wr && sel_out) begin
            for (int i = 0; i < BE_W; i++) begin
                if (bus_req_i.be[i]) begin
                    out_q[8*i +: 8] <= bus_req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        case (bus_req_i.addr[7:0])
            8'h00:   rdata_o = out_q;
            8'h04:   rdata_o = gpio_in_i;
            default: rdata_o = '0;
        endcase
    end

    assign leds_o = out_q[15:0];

endmodule

`default_nettype wire

//--- logic/tick_counter.sv
`timescale 1ns/100ps
`default_nettype none

module tick_counter import soc_pkg::*; (
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  bus_req_t          bus_req_i,
    output logic [DATA_W-1:0] rdata_o
);

    logic [DATA_W-1:0] cnt_q;

    // any write restarts the count from zero, whatever the data
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (bus_req_i.wr) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign rdata_o = cnt_q;

endmodule

`default_nettype wire

//--- logic/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_top import soc_pkg::*; #(
    parameter int ACCESS_CYCLES = 2
) (
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  bus_req_t          ibus_req_i,
    output bus_rsp_t          ibus_rsp_o,
    input  bus_req_t          dbus_req_i,
    output bus_rsp_t          dbus_rsp_o,

    output sram_pins_t        sram_o,
    input  logic [DATA_W-1:0] sram_rdata_i,

    input  logic [DATA_W-1:0] gpio_in_i,
    output logic [15:0]       leds_o
);

    bus_req_t          dbus_ram_req;
    bus_rsp_t          dbus_ram_rsp;
    bus_req_t          gpio_req;
    logic [DATA_W-1:0] gpio_rdata;
    bus_req_t          tick_req;
    logic [DATA_W-1:0] tick_rdata;

    // --------------------------------------------------
    // dbus address decode
    // --------------------------------------------------
    dbus_decoder u_dbus_decoder (
        .dbus_req_i   (dbus_req_i),
        .dbus_rsp_o   (dbus_rsp_o),
        .ram_req_o    (dbus_ram_req),
        .ram_rsp_i    (dbus_ram_rsp),
        .gpio_req_o   (gpio_req),
        .gpio_rdata_i (gpio_rdata),
        .tick_req_o   (tick_req),
        .tick_rdata_i (tick_rdata)
    );

    // --------------------------------------------------
    // shared external RAM
    // --------------------------------------------------

    // the ibus has no other target, so it goes straight to port A
    sram_ctrl #(
        .ACCESS_CYCLES (ACCESS_CYCLES)
    ) u_sram_ctrl (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .port_a_req_i (ibus_req_i),
        .port_a_rsp_o (ibus_rsp_o),
        .port_b_req_i (dbus_ram_req),
        .port_b_rsp_o (dbus_ram_rsp),
        .sram_o       (sram_o),
        .sram_rdata_i (sram_rdata_i)
    );

    // --------------------------------------------------
    // register peripherals
    // --------------------------------------------------
    gpio_regs u_gpio_regs (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .bus_req_i (gpio_req),
        .rdata_o   (gpio_rdata),
        .gpio_in_i (gpio_in_i),
        .leds_o    (leds_o)
    );

    tick_counter u_tick_counter (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .bus_req_i (tick_req),
        .rdata_o   (tick_rdata)
    );

endmodule

`default_nettype wire

//--- test/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker import soc_pkg::*; #(
    parameter int ACCESS_CYCLES = 2
) (
    input logic              clk_i,
    input logic              arst_n_i,
    input bus_req_t          ibus_req_i,
    input bus_rsp_t          ibus_rsp_i,
    input bus_req_t          dbus_req_i,
    input bus_rsp_t          dbus_rsp_i,
    input sram_pins_t        sram_i,
    input logic [DATA_W-1:0] gpio_in_i,
    input logic [15:0]       leds_i
);

    logic [DATA_W-1:0] shadow [logic [20:0]];
    logic [DATA_W-1:0] gpio_out = '0;
    sram_pins_t        prev_pins;
    // the ticker reads zero in cycle 1 after reset and again in the cycle after a write
    int tick_cycle = 1;
    int errors = 0;
    int test_errors = 0;
    int checks = 0;
    int tests = 0;
    int cycle = 0;
    int i_wait = 0;
    int d_wait = 0;

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    // power-up contents of both banks, shared with the SRAM model
    function automatic logic [31:0] fill_word(input logic bank, input logic [19:0] word);
        return {word[11:0], bank, word[19:1]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] ram_word(input logic [31:0] a);
        if (shadow.exists({a[22], a[21:2]})) begin
            return shadow[{a[22], a[21:2]}];
        end
        return fill_word(a[22], a[21:2]);
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                          input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        if ((a & RAM_MASK) == RAM_BASE) return ram_word(a);
        if ((a & PERIPH_MASK) == GPIO_BASE) begin
            if (a[7:0] == 8'h00) return gpio_out;
            if (a[7:0] == 8'h04) return gpio_in_i;
        end
        return '0;
    endfunction

    task automatic ref_write(input logic [31:0] a, input logic [31:0] wd, input logic [3:0] be);
        if ((a & RAM_MASK) == RAM_BASE) begin
            shadow[{a[22], a[21:2]}] = merge(ram_word(a), wd, be);
        end else if ((a & PERIPH_MASK) == GPIO_BASE && a[7:0] == 8'h00) begin
            gpio_out = merge(gpio_out, wd, be);
        end
    endtask

    // --------------------------------------------------
    // compare helpers
    // --------------------------------------------------
    task automatic report_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    // the last strobe cycle is the one just before completion
    task automatic check_pins(input bus_req_t req);
        compare(32'({prev_pins.base_ce_n, prev_pins.ext_ce_n}),
                32'(req.addr[22] ? 2'b10 : 2'b01), "bank chip enables");
        compare(32'(prev_pins.addr), 32'(req.addr[21:2]), "sram word address");
        compare(32'(prev_pins.we_n), 32'(!req.wr), "sram we_n");
    endtask

    task automatic check_wait(input int n, input string port);
        checks++;
        if (n > 2 * ACCESS_CYCLES + 3) begin
            report_error($sformatf("%s stalled %0d cycles, longer than one other access", port, n));
        end
    endtask

    task automatic complete_dbus();
        bus_req_t r;
        logic     is_tick;
        r = dbus_req_i;
        is_tick = (r.addr & PERIPH_MASK) == TICK_BASE;
        if ((r.addr & RAM_MASK) == RAM_BASE) begin
            check_pins(r);
            check_wait(d_wait, "dbus");
        end else begin
            compare(32'(d_wait), 0, "peripheral stall cycles");
            if (!ibus_req_i.rd) begin
                compare(32'({sram_i.base_ce_n, sram_i.ext_ce_n, sram_i.oe_n, sram_i.we_n}),
                        32'hf, "sram controls during peripheral access");
            end
        end
        if (is_tick) begin
            if (r.wr) begin
                tick_cycle = cycle + 1;
            end else begin
                compare(dbus_rsp_i.rdata, 32'(cycle - tick_cycle), "tick read");
            end
        end else if (r.rd) begin
            compare(dbus_rsp_i.rdata, ref_read(r.addr), $sformatf("dbus read %h", r.addr));
        end else begin
            ref_write(r.addr, r.wdata, r.be);
        end
    endtask

    // sampled mid-cycle, where the DUT outputs have settled
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            i_wait = 0;
            d_wait = 0;
        end else begin
            cycle++;
            compare(32'(leds_i), 32'(gpio_out[15:0]), "leds");
            if (ibus_req_i.rd) begin
                if (ibus_rsp_i.stall) begin
                    i_wait++;
                end else begin
                    compare(ibus_rsp_i.rdata, ram_word(ibus_req_i.addr), "ibus read");
                    check_pins(ibus_req_i);
                    check_wait(i_wait, "ibus");
                    i_wait = 0;
                end
            end
            if (dbus_req_i.rd || dbus_req_i.wr) begin
                if (dbus_rsp_i.stall) begin
                    d_wait++;
                end else begin
                    complete_dbus();
                    d_wait = 0;
                end
            end
            prev_pins = sram_i;
        end
    end

    task automatic check_reset_state();
        compare(32'(ibus_rsp_i.stall), 0, "ibus stall after reset");
        compare(32'(dbus_rsp_i.stall), 0, "dbus stall after reset");
        compare(32'({sram_i.base_ce_n, sram_i.ext_ce_n, sram_i.oe_n, sram_i.we_n, sram_i.be_n}),
                32'hff, "sram controls after reset");
        compare(32'(leds_i), 0, "leds after reset");
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic report_counts();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    endtask

endmodule

`default_nettype wire

//--- test/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top import soc_pkg::*; ;

    localparam int ACCESS_CYCLES = 2;
    localparam int WAIT_LIMIT    = 64;

    logic              clk;
    logic              arst_n;
    bus_req_t          ibus_req;
    bus_rsp_t          ibus_rsp;
    bus_req_t          dbus_req;
    bus_rsp_t          dbus_rsp;
    sram_pins_t        sram;
    logic [DATA_W-1:0] sram_rdata;
    logic [DATA_W-1:0] gpio_in;
    logic [15:0]       leds;
    logic [31:0]       rng;
    logic [31:0]       base_mem [0:(1<<SRAM_AW)-1];
    logic [31:0]       ext_mem  [0:(1<<SRAM_AW)-1];
    logic [31:0]       ram_pool [$];
    logic              timed_out = 1'b0;
    string             timeout_msg;

    soc_top #(.ACCESS_CYCLES(ACCESS_CYCLES)) dut (
        .clk_i(clk), .arst_n_i(arst_n),
        .ibus_req_i(ibus_req), .ibus_rsp_o(ibus_rsp),
        .dbus_req_i(dbus_req), .dbus_rsp_o(dbus_rsp),
        .sram_o(sram), .sram_rdata_i(sram_rdata),
        .gpio_in_i(gpio_in), .leds_o(leds)
    );

    tb_checker #(.ACCESS_CYCLES(ACCESS_CYCLES)) chk (
        .clk_i(clk), .arst_n_i(arst_n),
        .ibus_req_i(ibus_req), .ibus_rsp_i(ibus_rsp),
        .dbus_req_i(dbus_req), .dbus_rsp_i(dbus_rsp),
        .sram_i(sram), .gpio_in_i(gpio_in), .leds_i(leds)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // SRAM bank model
    // --------------------------------------------------
    assign sram_rdata = (!sram.oe_n && !sram.base_ce_n) ? base_mem[sram.addr] :
                        (!sram.oe_n && !sram.ext_ce_n)  ? ext_mem[sram.addr]  : '0;

    always @(posedge clk) begin
        for (int b = 0; b < BE_W; b++) begin
            if (!sram.we_n && !sram.be_n[b]) begin
                if (!sram.base_ce_n) base_mem[sram.addr][8*b +: 8] <= sram.wdata[8*b +: 8];
                if (!sram.ext_ce_n) ext_mem[sram.addr][8*b +: 8] <= sram.wdata[8*b +: 8];
            end
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] rand_ram_addr();
        return RAM_BASE | (next_rand() & 32'h007f_fffc);
    endfunction

    task automatic raise_timeout(input string msg);
        timeout_msg = msg;
        timed_out   = 1'b1;
    endtask

    // a bus that never completes ends the run here
    initial begin
        wait (timed_out);
        $display("%s", timeout_msg);
        $display("sim failed");
        $finish;
    end

    // --------------------------------------------------
    // bus masters
    // --------------------------------------------------

    // callers start just after a rising edge and the next request follows with no idle cycle
    task automatic dbus_access(input logic wr, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be);
        int n;
        n = 0;
        dbus_req = '{addr: addr, wdata: wdata, be: be, rd: !wr, wr: wr};
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) raise_timeout("timeout: dbus stall never dropped");
        end while (dbus_rsp.stall && !timed_out);
        @(posedge clk);
        #1;
        dbus_req.rd = 1'b0;
        dbus_req.wr = 1'b0;
    endtask

    task automatic ibus_read(input logic [31:0] addr);
        int n;
        n = 0;
        ibus_req = '{addr: addr, wdata: '0, be: 4'hf, rd: 1'b1, wr: 1'b0};
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) raise_timeout("timeout: ibus stall never dropped");
        end while (ibus_rsp.stall && !timed_out);
        @(posedge clk);
        #1;
        ibus_req.rd = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        rng      = 32'ha69764f6;
        arst_n   = 1'b0;
        ibus_req = '0;
        dbus_req = '0;
        gpio_in  = next_rand();
        for (int i = 0; i < (1 << SRAM_AW); i++) begin
            base_mem[i] = chk.fill_word(1'b0, 20'(i));
            ext_mem[i]  = chk.fill_word(1'b1, 20'(i));
        end
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;

        @(negedge clk);
        chk.check_reset_state();
        chk.end_test("reset state");
        @(posedge clk);
        #1;

        repeat (40) begin
            r = next_rand();
            ram_pool.push_back(rand_ram_addr());
            dbus_access(1'b1, ram_pool[$], next_rand(), r[3:0]);
        end
        foreach (ram_pool[i]) dbus_access(1'b0, ram_pool[i], '0, 4'hf);
        repeat (8) dbus_access(1'b0, rand_ram_addr(), '0, 4'hf);
        chk.end_test("ram write and read");

        fork
            for (int i = 0; i < 24; i++) ibus_read(ram_pool[i]);
            for (int k = 0; k < 24; k++) dbus_access(k[0], ram_pool[k + 10], next_rand(), 4'hf);
        join
        chk.end_test("ibus and dbus contention");

        dbus_access(1'b1, GPIO_BASE, next_rand(), 4'hf);
        dbus_access(1'b0, GPIO_BASE, '0, 4'hf);
        dbus_access(1'b1, GPIO_BASE, next_rand(), 4'b0101);
        dbus_access(1'b0, GPIO_BASE, '0, 4'hf);
        dbus_access(1'b0, GPIO_BASE + 32'h4, '0, 4'hf);
        dbus_access(1'b0, GPIO_BASE + 32'h8, '0, 4'hf);
        chk.end_test("gpio");

        dbus_access(1'b0, 32'h0000_1000, '0, 4'hf);
        dbus_access(1'b1, ram_pool[0] & 32'h007f_fffc, next_rand(), 4'hf);
        dbus_access(1'b1, GPIO_BASE + 32'h200, next_rand(), 4'hf);
        dbus_access(1'b1, 32'h9000_0000, next_rand(), 4'hf);
        dbus_access(1'b0, ram_pool[0], '0, 4'hf);
        dbus_access(1'b0, GPIO_BASE, '0, 4'hf);
        chk.end_test("unmapped");

        dbus_access(1'b0, TICK_BASE, '0, 4'hf);
        repeat (5) @(posedge clk);
        #1;
        dbus_access(1'b0, TICK_BASE, '0, 4'hf);
        dbus_access(1'b1, TICK_BASE, next_rand(), 4'hf);
        dbus_access(1'b0, TICK_BASE, '0, 4'hf);
        dbus_access(1'b0, TICK_BASE, '0, 4'hf);
        chk.end_test("ticker");

        chk.report_counts();
        if (chk.errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/soc_pkg.sv
logic/dbus_decoder.sv
logic/sram_ctrl.sv
logic/gpio_regs.sv
logic/tick_counter.sv
logic/soc_top.sv
test/tb_checker.sv
test/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_top
FILELIST  := all.f

SOURCES := $(shell cat $(FILELIST))
BIN     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@! grep -q "sim failed" $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
